/* hdl/snake_pkg.sv */
package snake_pkg;

	// one board position, row 0 at the top, column 0 at the left
	typedef struct packed {
		logic [2:0] row;
		logic [2:0] col;
	} cell_t;

	typedef enum logic [1:0] {
		dir_up,
		dir_down,
		dir_left,
		dir_right
	} dir_e;

	typedef enum logic {
		st_playing,
		st_over
	} play_state_e;

	// bit 7 is column 0
	typedef logic [7:0] row_bits_t;

	// everything the display needs to draw the board
	typedef struct packed {
		row_bits_t [7:0] occupancy;
		cell_t           head;
		cell_t           apple;
	} board_view_t;

	// three packed BCD digits, hundreds in the top nibble
	typedef logic [11:0] bcd3_t;

	// segment a in bit 7, decimal point in bit 0
	typedef logic [7:0] seg_t;

	// 1 to 64 cells
	typedef logic [6:0] snake_len_t;

	localparam seg_t segment_patterns [0:9] = '{
		8'b11111100,
		8'b01100000,
		8'b11011010,
		8'b11110010,
		8'b01100110,
		8'b10110110,
		8'b10111110,
		8'b11100000,
		8'b11111110,
		8'b11110110
	};

endpackage

/* hdl/tick_gen.sv */
`timescale 1ns/100ps

module tick_gen #(
	parameter int unsigned STEP_CYCLES   = 5_000_000,
	parameter int unsigned SECOND_CYCLES = 10_000_000,
	parameter int unsigned SCAN_CYCLES   = 8_192
) (
	input  logic                   clk,
	input  logic                   reset,
	input  snake_pkg::play_state_e state,
	output logic                   step_tick,
	output logic                   second_tick,
	output logic                   scan_tick
);

	// widest period sets the counter width
	localparam int unsigned MAX_AB = (STEP_CYCLES > SECOND_CYCLES) ? STEP_CYCLES : SECOND_CYCLES;
	localparam int unsigned MAX_CYCLES = (MAX_AB > SCAN_CYCLES) ? MAX_AB : SCAN_CYCLES;
	localparam int CNT_W = $clog2(MAX_CYCLES + 1);

	// index 0 step, 1 second, 2 scan
	localparam int unsigned periods [0:2] = '{STEP_CYCLES, SECOND_CYCLES, SCAN_CYCLES};

	logic [CNT_W-1:0] cnt_q [0:2];
	logic [2:0]       tick_q;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			cnt_q  <= '{default: '0};
			tick_q <= '0;
		end else begin
			for (int i = 0; i < 3; i++) begin
				if (cnt_q[i] == CNT_W'(periods[i] - 1)) begin
					cnt_q[i]  <= '0;
					tick_q[i] <= 1'b1;
				end else begin
					cnt_q[i]  <= cnt_q[i] + 1'b1;
					tick_q[i] <= 1'b0;
				end
			end
		end
	end

	assign step_tick   = tick_q[0];
	// play timer stops once the game is over
	assign second_tick = tick_q[1] && (state == snake_pkg::st_playing);
	assign scan_tick   = tick_q[2];

endmodule

/* hdl/snake_engine.sv */
`timescale 1ns/100ps

module snake_engine (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   step_tick,
	input  logic                   arrow_up,
	input  logic                   arrow_down,
	input  logic                   arrow_left,
	input  logic                   arrow_right,
	output snake_pkg::board_view_t board_view,
	output snake_pkg::play_state_e state,
	output logic                   apple_eaten
);

	snake_pkg::play_state_e  state_q;
	snake_pkg::dir_e         dir_q;
	snake_pkg::dir_e         dir_next;
	snake_pkg::snake_len_t   len_q;
	snake_pkg::snake_len_t   len_next;
	snake_pkg::cell_t        head_q;
	snake_pkg::cell_t        head_next;
	snake_pkg::cell_t        apple_q;
	snake_pkg::cell_t        apple_next;
	snake_pkg::cell_t        body_q [1:62];
	snake_pkg::cell_t        seg_next [0:63];
	snake_pkg::row_bits_t [7:0] occ_q;
	snake_pkg::row_bits_t [7:0] occ_next;
	logic [7:0]              lfsr_q;
	logic                    hit;
	logic                    eat;
	logic                    advance;

	assign advance = step_tick && (state_q == snake_pkg::st_playing);

	// highest priority arrow wins, a reversal is dropped
	always_comb begin
		dir_next = dir_q;
		if (arrow_up) begin
			if (dir_q != snake_pkg::dir_down)
				dir_next = snake_pkg::dir_up;
		end else if (arrow_down) begin
			if (dir_q != snake_pkg::dir_up)
				dir_next = snake_pkg::dir_down;
		end else if (arrow_left) begin
			if (dir_q != snake_pkg::dir_right)
				dir_next = snake_pkg::dir_left;
		end else if (arrow_right) begin
			if (dir_q != snake_pkg::dir_left)
				dir_next = snake_pkg::dir_right;
		end
	end

	// 3-bit arithmetic gives the wrap at the edges
	always_comb begin
		head_next = head_q;
		case (dir_next)
			snake_pkg::dir_up:    head_next.row = head_q.row - 3'd1;
			snake_pkg::dir_down:  head_next.row = head_q.row + 3'd1;
			snake_pkg::dir_left:  head_next.col = head_q.col - 3'd1;
			default:              head_next.col = head_q.col + 3'd1;
		endcase
	end

	// body after the shift, segment k takes k-1
	always_comb begin
		seg_next[0] = head_next;
		seg_next[1] = head_q;
		for (int k = 2; k < 64; k++) begin
			seg_next[k] = body_q[k-1];
		end
	end

	always_comb begin
		hit = 1'b0;
		for (int k = 1; k < 64; k++) begin
			if (k < len_q && seg_next[k] == head_next)
				hit = 1'b1;
		end
	end

	assign eat      = !hit && (head_next == apple_q) && (len_q < 7'd64);
	assign len_next = eat ? len_q + 7'd1 : len_q;

	// map of the board after this step, head included
	always_comb begin
		occ_next = '0;
		for (int k = 0; k < 64; k++) begin
			if (k < len_next)
				occ_next[seg_next[k].row][~seg_next[k].col] = 1'b1;
		end
	end

	// first free cell upward from the lfsr, wrapping
	always_comb begin
		logic [5:0] pos;
		logic       found;
		found      = 1'b0;
		apple_next = apple_q;
		for (int i = 0; i < 64; i++) begin
			pos = lfsr_q[5:0] + 6'(i);
			if (!found && !occ_next[pos[5:3]][~pos[2:0]]) begin
				found      = 1'b1;
				apple_next = pos;
			end
		end
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state_q     <= snake_pkg::st_playing;
			dir_q       <= snake_pkg::dir_down;
			len_q       <= 7'd1;
			head_q      <= '{row: 3'd0, col: 3'd0};
			apple_q     <= '{row: 3'd3, col: 3'd4};
			occ_q       <= '{0: 8'b1000_0000, default: 8'h00};
			lfsr_q      <= 8'hb5;
			apple_eaten <= 1'b0;
		end else begin
			apple_eaten <= 1'b0;
			if (advance) begin
				dir_q  <= dir_next;
				head_q <= head_next;
				len_q  <= len_next;
				occ_q  <= occ_next;
				// taps 8,6,5,4
				lfsr_q <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
				if (hit || len_next == 7'd64)
					state_q <= snake_pkg::st_over;
				if (eat) begin
					apple_eaten <= 1'b1;
					apple_q     <= apple_next;
				end
			end
		end
	end

	// body cells move one place down the chain each step
	always_ff @(posedge clk) begin
		if (advance) begin
			for (int k = 1; k < 63; k++) begin
				body_q[k] <= seg_next[k];
			end
		end
	end

	assign board_view.occupancy = occ_q;
	assign board_view.head      = head_q;
	assign board_view.apple     = apple_q;
	assign state                = state_q;

endmodule

/* hdl/bcd_counter.sv */
`timescale 1ns/100ps

module bcd_counter (
	input  logic             clk,
	input  logic             reset,
	input  logic             inc,
	output snake_pkg::bcd3_t value
);

	snake_pkg::bcd3_t value_q;
	snake_pkg::bcd3_t value_next;

	// ripple the decimal carry through the three digits
	always_comb begin
		logic carry;
		carry      = inc;
		value_next = value_q;
		for (int d = 0; d < 3; d++) begin
			if (carry) begin
				if (value_q[d*4 +: 4] == 4'd9) begin
					value_next[d*4 +: 4] = 4'd0;
				end else begin
					value_next[d*4 +: 4] = value_q[d*4 +: 4] + 4'd1;
					carry = 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset)
			value_q <= '0;
		else
			value_q <= value_next;
	end

	assign value = value_q;

endmodule

/* hdl/display_scan.sv */
`timescale 1ns/100ps

module display_scan (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   scan_tick,
	input  snake_pkg::board_view_t board_view,
	input  snake_pkg::bcd3_t       time_bcd,
	input  snake_pkg::bcd3_t       score_bcd,
	output snake_pkg::row_bits_t   matrix_scan,
	output snake_pkg::row_bits_t   matrix_red,
	output snake_pkg::row_bits_t   matrix_green,
	output logic [2:0]             led_scan,
	output snake_pkg::seg_t        led_seg
);

	logic [2:0]           row_q;
	logic [3:0]           digit;
	snake_pkg::row_bits_t red_row;
	snake_pkg::seg_t      seg_next;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset)
			row_q <= 3'd0;
		else if (scan_tick)
			row_q <= row_q + 3'd1;
	end

	// head and apple in red, may share a row
	always_comb begin
		red_row = '0;
		if (board_view.head.row == row_q)
			red_row[~board_view.head.col] = 1'b1;
		if (board_view.apple.row == row_q)
			red_row[~board_view.apple.col] = 1'b1;
	end

	// timer on the left three digits, score on the right
	always_comb begin
		case (row_q)
			3'd0:    digit = time_bcd[11:8];
			3'd1:    digit = time_bcd[7:4];
			3'd2:    digit = time_bcd[3:0];
			3'd3:    digit = score_bcd[11:8];
			3'd4:    digit = score_bcd[7:4];
			3'd5:    digit = score_bcd[3:0];
			default: digit = 4'd0;
		endcase
	end

	always_comb begin
		if (row_q < 3'd6 && digit <= 4'd9)
			seg_next = snake_pkg::segment_patterns[digit];
		else
			seg_next = '0;
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			matrix_scan  <= 8'b0000_0001;
			matrix_red   <= '0;
			matrix_green <= '0;
			led_scan     <= 3'd0;
			led_seg      <= '0;
		end else begin
			matrix_scan  <= 8'b0000_0001 << row_q;
			matrix_red   <= red_row;
			matrix_green <= board_view.occupancy[row_q];
			// blank digits park on position 0
			led_scan     <= (row_q < 3'd6) ? row_q : 3'd0;
			led_seg      <= seg_next;
		end
	end

endmodule

/* hdl/snake_game_top.sv */
`timescale 1ns/100ps

module snake_game_top #(
	parameter int unsigned STEP_CYCLES   = 5_000_000,
	parameter int unsigned SECOND_CYCLES = 10_000_000,
	parameter int unsigned SCAN_CYCLES   = 8_192
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 arrow_up,
	input  logic                 arrow_down,
	input  logic                 arrow_left,
	input  logic                 arrow_right,
	output snake_pkg::row_bits_t matrix_scan,
	output snake_pkg::row_bits_t matrix_red,
	output snake_pkg::row_bits_t matrix_green,
	output logic [2:0]           led_scan,
	output snake_pkg::seg_t      led_seg
);

	logic                   step_tick;
	logic                   second_tick;
	logic                   scan_tick;
	logic                   apple_eaten;
	snake_pkg::play_state_e state;
	snake_pkg::board_view_t board_view;
	snake_pkg::bcd3_t       time_bcd;
	snake_pkg::bcd3_t       score_bcd;

	tick_gen #(
		.STEP_CYCLES   (STEP_CYCLES),
		.SECOND_CYCLES (SECOND_CYCLES),
		.SCAN_CYCLES   (SCAN_CYCLES)
	) u_tick_gen (
		.clk         (clk),
		.reset       (reset),
		.state       (state),
		.step_tick   (step_tick),
		.second_tick (second_tick),
		.scan_tick   (scan_tick)
	);

	snake_engine u_engine (
		.clk         (clk),
		.reset       (reset),
		.step_tick   (step_tick),
		.arrow_up    (arrow_up),
		.arrow_down  (arrow_down),
		.arrow_left  (arrow_left),
		.arrow_right (arrow_right),
		.board_view  (board_view),
		.state       (state),
		.apple_eaten (apple_eaten)
	);

	// apples eaten
	bcd_counter score_counter (
		.clk   (clk),
		.reset (reset),
		.inc   (apple_eaten),
		.value (score_bcd)
	);

	// seconds of play
	bcd_counter time_counter (
		.clk   (clk),
		.reset (reset),
		.inc   (second_tick),
		.value (time_bcd)
	);

	display_scan u_display (
		.clk          (clk),
		.reset        (reset),
		.scan_tick    (scan_tick),
		.board_view   (board_view),
		.time_bcd     (time_bcd),
		.score_bcd    (score_bcd),
		.matrix_scan  (matrix_scan),
		.matrix_red   (matrix_red),
		.matrix_green (matrix_green),
		.led_scan     (led_scan),
		.led_seg      (led_seg)
	);

endmodule

/* tb/tb_snake_tasks.svh */
task automatic stop_with_failure();
	$display("Result: FAILED");
	$fatal(1, "simulation stopped at the first error");
endtask

task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
	if (actual !== expected) begin
		$display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected);
		stop_with_failure();
	end
endtask

// one clock, landing just after the rising edge
task automatic next_cycle();
	@(posedge clk);
	#(drive_delay);
endtask

// the engine moves on the clock after this tick
task automatic wait_step();
	int waited;
	waited = 0;
	do begin
		next_cycle();
		waited++;
		if (waited > 2 * step_cycles) begin
			$display("ERROR: no game step tick came within %0d clocks", 2 * step_cycles);
			stop_with_failure();
		end
	end while (dut.step_tick !== 1'b1);
endtask

// first clock on which row r is shown
task automatic wait_row(input int r);
	logic [7:0] prev;
	int         waited;
	waited = 0;
	do begin
		prev = matrix_scan;
		next_cycle();
		waited++;
		if (waited > 16 * scan_cycles) begin
			$display("ERROR: matrix row %0d was never selected by the scan", r);
			stop_with_failure();
		end
	end while (!(matrix_scan == (8'h01 << r) && prev != matrix_scan));
endtask

function automatic int seg_to_digit(input logic [7:0] seg);
	int digit;
	digit = 15;
	for (int i = 0; i < 10; i++) begin
		if (seg == digit_segments[i])
			digit = i;
	end
	return digit;
endfunction

// one full scan from a fresh row 0
task automatic sample_frame();
	int heads;
	int apples;
	heads     = 0;
	apples    = 0;
	snake_len = 0;
	for (int r = 0; r < 8; r++) begin
		wait_row(r);
		row_cycle[r] = cycle_count;
		seg_rows[r]  = led_seg;
		for (int c = 0; c < 8; c++) begin
			// column 0 sits in bit 7
			if (matrix_green[7-c])
				snake_len++;
			if (matrix_red[7-c] && matrix_green[7-c]) begin
				heads++;
				head_row = r;
				head_col = c;
			end else if (matrix_red[7-c]) begin
				apples++;
				apple_row = r;
				apple_col = c;
			end
		end
		check_value("led_scan", led_scan, (r < 6) ? r : 0);
		if (r >= 6)
			check_value("led_seg", led_seg, 0);
	end
	check_value("head cells", heads, 1);
	check_value("apple cells", apples, 1);
	score = 100 * seg_to_digit(seg_rows[3]) + 10 * seg_to_digit(seg_rows[4])
		+ seg_to_digit(seg_rows[5]);
endtask

/* tb/tb_snake_game.sv */
`timescale 1ns/100ps

module tb_snake_game;

	localparam int step_cycles   = 64;
	localparam int second_cycles = 160;
	localparam int scan_cycles   = 4;
	localparam int drive_delay   = 5;
	// counter update, then the display register
	localparam int timer_lag     = 2;

	// arrow codes, opposite directions differ in bit 0
	localparam logic [1:0] press_up    = 2'd0;
	localparam logic [1:0] press_down  = 2'd1;
	localparam logic [1:0] press_left  = 2'd2;
	localparam logic [1:0] press_right = 2'd3;

	// digit patterns, segment a in bit 7
	localparam logic [7:0] digit_segments [0:9] = '{
		8'hfc, 8'h60, 8'hda, 8'hf2, 8'h66, 8'hb6, 8'hbe, 8'he0, 8'hfe, 8'hf6
	};

	typedef struct packed {
		logic [1:0] arrow;
		logic [3:0] steps;
		logic [2:0] row;
		logic [2:0] col;
		logic [7:0] score;
		logic [6:0] length;
	} stim_t;

	// wrap and reversal first, then down three and right four onto the apple
	localparam stim_t stim_table [0:7] = '{
		'{press_right, 4'd1, 3'd0, 3'd1, 8'd0, 7'd1},
		'{press_up,    4'd1, 3'd7, 3'd1, 8'd0, 7'd1},
		'{press_down,  4'd2, 3'd5, 3'd1, 8'd0, 7'd1},
		'{press_right, 4'd6, 3'd5, 3'd7, 8'd0, 7'd1},
		'{press_left,  4'd1, 3'd5, 3'd0, 8'd0, 7'd1},
		'{press_down,  4'd3, 3'd0, 3'd0, 8'd0, 7'd1},
		'{press_down,  4'd3, 3'd3, 3'd0, 8'd0, 7'd1},
		'{press_right, 4'd4, 3'd3, 3'd4, 8'd1, 7'd2}
	};

	logic       clk;
	logic       reset;
	logic       arrow_up;
	logic       arrow_down;
	logic       arrow_left;
	logic       arrow_right;
	logic [7:0] matrix_scan;
	logic [7:0] matrix_red;
	logic [7:0] matrix_green;
	logic [2:0] led_scan;
	logic [7:0] led_seg;

	// last frame read from the display
	logic [7:0] seg_rows [0:7];
	int         row_cycle [0:7];
	int         head_row;
	int         head_col;
	int         apple_row;
	int         apple_col;
	int         snake_len;
	int         score;

	// expected game state
	logic [1:0] cur_dir;
	int         exp_row;
	int         exp_col;
	int         exp_len;
	int         exp_cells;
	int         exp_score;
	// segments as row * 8 + col, head first
	int         body_cells [$];
	int         cycle_count;
	integer     seed;

	snake_game_top #(
		.STEP_CYCLES   (step_cycles),
		.SECOND_CYCLES (second_cycles),
		.SCAN_CYCLES   (scan_cycles)
	) dut (
		.clk          (clk),
		.reset        (reset),
		.arrow_up     (arrow_up),
		.arrow_down   (arrow_down),
		.arrow_left   (arrow_left),
		.arrow_right  (arrow_right),
		.matrix_scan  (matrix_scan),
		.matrix_red   (matrix_red),
		.matrix_green (matrix_green),
		.led_scan     (led_scan),
		.led_seg      (led_seg)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// clocks since reset release
	always @(posedge clk) begin
		if (!reset)
			cycle_count <= 0;
		else
			cycle_count <= cycle_count + 1;
	end

	`include "tb_snake_tasks.svh"

	task automatic press(input logic [1:0] code);
		arrow_up    = (code == press_up);
		arrow_down  = (code == press_down);
		arrow_left  = (code == press_left);
		arrow_right = (code == press_right);
	endtask

	// timer digits against completed second periods at each digit's capture
	task automatic check_timer();
		int secs;
		int expected;
		for (int d = 0; d < 3; d++) begin
			secs = (row_cycle[d] - timer_lag) / second_cycles;
			expected = (d == 0) ? (secs / 100) % 10 : (d == 1) ? (secs / 10) % 10 : secs % 10;
			check_value("timer digit", seg_to_digit(seg_rows[d]), expected);
		end
	endtask

	// one game step with an arrow held, checked against the movement rules
	task automatic run_step(input logic [1:0] code);
		int old_apple_row;
		int old_apple_col;
		bit bite;
		old_apple_row = apple_row;
		old_apple_col = apple_col;
		press(code);
		wait_step();
		if (code != (cur_dir ^ 2'd1))
			cur_dir = code;
		case (cur_dir)
			press_up:   exp_row = (exp_row + 7) % 8;
			press_down: exp_row = (exp_row + 1) % 8;
			press_left: exp_col = (exp_col + 7) % 8;
			default:    exp_col = (exp_col + 1) % 8;
		endcase
		// shifted segments 1 to length-1 are the old 0 to length-2
		bite = 1'b0;
		for (int k = 0; k < body_cells.size() - 1; k++) begin
			if (body_cells[k] == exp_row * 8 + exp_col)
				bite = 1'b1;
		end
		body_cells.push_front(exp_row * 8 + exp_col);
		if (exp_row == old_apple_row && exp_col == old_apple_col) begin
			exp_len++;
			exp_score++;
		end else begin
			body_cells.delete(body_cells.size() - 1);
		end
		// a bitten cell is lit once for two segments
		exp_cells = bite ? exp_len - 1 : exp_len;
		sample_frame();
		check_value("head_row", head_row, exp_row);
		check_value("head_col", head_col, exp_col);
		check_value("score", score, exp_score);
		check_value("length", snake_len, exp_cells);
		check_timer();
	endtask

	initial begin
		int          idle;
		int          steps_taken;
		int          bite_row;
		int          bite_col;
		logic [1:0]  choice;
		logic [23:0] frozen_time;
		reset       = 1'b0;
		arrow_up    = 1'b0;
		arrow_down  = 1'b0;
		arrow_left  = 1'b0;
		arrow_right = 1'b0;
		seed        = 32'ha79a;
		cur_dir     = press_down;
		exp_row     = 0;
		exp_col     = 0;
		exp_len     = 1;
		exp_cells   = 1;
		exp_score   = 0;
		body_cells.push_back(0);
		repeat (5) @(posedge clk);
		#(drive_delay);
		reset = 1'b1;

		sample_frame();
		check_value("head_row", head_row, 0);
		check_value("head_col", head_col, 0);
		check_value("apple_row", apple_row, 3);
		check_value("apple_col", apple_col, 4);
		check_value("score", score, 0);
		check_value("length", snake_len, 1);
		check_timer();

		for (int i = 0; i < 8; i++) begin
			for (int s = 0; s < stim_table[i].steps; s++)
				run_step(stim_table[i].arrow);
			check_value("head_row", head_row, stim_table[i].row);
			check_value("head_col", head_col, stim_table[i].col);
			check_value("score", score, stim_table[i].score);
			check_value("length", snake_len, stim_table[i].length);
			idle = $random(seed) & 15;
			repeat (idle) next_cycle();
		end

		// chase apples with down and right moves only
		steps_taken = 0;
		while (exp_len < 5) begin
			if (apple_row != head_row)
				choice = (cur_dir == press_up || cur_dir == press_down) ? cur_dir : press_down;
			else
				choice = (cur_dir == press_left || cur_dir == press_right) ? cur_dir : press_right;
			run_step(choice);
			steps_taken++;
			if (steps_taken > 200) begin
				$display("ERROR: the snake did not grow to five cells within 200 steps");
				stop_with_failure();
			end
		end

		// a tight square runs the head into its own tail
		bite_row = head_row;
		bite_col = head_col;
		run_step(press_down);
		run_step(press_right);
		run_step(press_up);
		run_step(press_left);
		check_value("head_row", head_row, bite_row);
		check_value("head_col", head_col, bite_col);

		frozen_time = {seg_rows[0], seg_rows[1], seg_rows[2]};
		repeat (4) begin
			wait_step();
			sample_frame();
			check_value("head_row", head_row, bite_row);
			check_value("head_col", head_col, bite_col);
			check_value("timer segments", {seg_rows[0], seg_rows[1], seg_rows[2]}, frozen_time);
			check_value("length", snake_len, exp_cells);
		end

		$display("Result: PASSED");
		$finish;
	end

endmodule

/* snake_game.f */
+incdir+tb
hdl/snake_pkg.sv
hdl/tick_gen.sv
hdl/snake_engine.sv
hdl/bcd_counter.sv
hdl/display_scan.sv
hdl/snake_game_top.sv
tb/tb_snake_game.sv

/* Bender.yml */
package:
  name: snake_game

sources:
  - hdl/snake_pkg.sv
  - hdl/tick_gen.sv
  - hdl/snake_engine.sv
  - hdl/bcd_counter.sv
  - hdl/display_scan.sv
  - hdl/snake_game_top.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/tb_snake_game.sv
